// File: hdl/fp32_fmt_pkg.sv
`default_nettype none

// input number format, ieee single precision
package fp32_fmt_pkg;

  // elements per block
  localparam int block_size_lp = 32;

  // full word width
  localparam int fp_width_lp = 32;

  // biased exponent field
  localparam int exp_width_lp = 8;

  // fraction field, hidden bit not stored
  localparam int frac_width_lp = 23;

  // one input word, seen raw or split into fields
  // raw view at the ports, field view inside decode
  typedef union packed {
    logic [fp_width_lp-1:0] raw;
    struct packed {
      logic                     sign;
      logic [exp_width_lp-1:0]  exp;
      logic [frac_width_lp-1:0] frac;
    } fields;
  } fp32_word_u;

endpackage

`default_nettype wire

// File: hdl/bfp_code_pkg.sv
`default_nettype none

// output code format of the block quantizer
package bfp_code_pkg;

  // hidden bit plus top 4 fraction bits
  localparam int mag_width_lp = 5;

  // sign on top of the magnitude
  localparam int code_width_lp = mag_width_lp + 1;

  // alignment shift, saturates at mag_width_lp
  // so it must be able to hold that value itself
  localparam int shift_width_lp = $clog2(mag_width_lp + 1);

  // in_valid_i to out_valid_o, one cycle per stage
  localparam int latency_lp = 3;

endpackage

`default_nettype wire

// File: hdl/bfp_exp_decode.sv
`timescale 1ns/10ps
`default_nettype none

// stage 1: field split and shared exponent search
module bfp_exp_decode
  import fp32_fmt_pkg::*, bfp_code_pkg::*;
(
  input  logic                    clk,
  input  logic                    reset_i,
  input  logic                    in_valid_i,
  input  fp32_word_u              block_i [block_size_lp],
  output logic                    valid_o,
  output logic                    sign_o [block_size_lp],
  output logic [exp_width_lp-1:0] exp_o [block_size_lp],
  output logic [mag_width_lp-1:0] sig_o [block_size_lp],
  output logic [exp_width_lp-1:0] max_exp_o
);

  // one comparator node of the tree
  function automatic logic [exp_width_lp-1:0] exp_max(
    input logic [exp_width_lp-1:0] a,
    input logic [exp_width_lp-1:0] b
  );
    exp_max = (a >= b) ? a : b;
  endfunction

  // tree levels, leaves first
  logic [exp_width_lp-1:0] lvl0 [block_size_lp];
  logic [exp_width_lp-1:0] lvl1 [block_size_lp/2];
  logic [exp_width_lp-1:0] lvl2 [block_size_lp/4];
  logic [exp_width_lp-1:0] lvl3 [block_size_lp/8];
  logic [exp_width_lp-1:0] lvl4 [block_size_lp/16];
  logic [exp_width_lp-1:0] max_exp;

  // leading significand bits per element
  logic [mag_width_lp-1:0] sig [block_size_lp];

  // field view of each word
  always_comb begin
    for (int i = 0; i < block_size_lp; i++) begin
      lvl0[i] = block_i[i].fields.exp;
      // hidden bit only for normal numbers
      sig[i]  = {|block_i[i].fields.exp,
                 block_i[i].fields.frac[frac_width_lp-1 -: mag_width_lp-1]};
    end
  end

  // level 1, neighbouring words paired
  // 16 nodes
  for (genvar k = 0; k < block_size_lp/2; k++) begin : g_lvl1
    assign lvl1[k] = exp_max(lvl0[2*k], lvl0[2*k+1]);
  end

  // level 2
  // 8 nodes
  for (genvar k = 0; k < block_size_lp/4; k++) begin : g_lvl2
    assign lvl2[k] = exp_max(lvl1[2*k], lvl1[2*k+1]);
  end

  // level 3
  // 4 nodes
  for (genvar k = 0; k < block_size_lp/8; k++) begin : g_lvl3
    assign lvl3[k] = exp_max(lvl2[2*k], lvl2[2*k+1]);
  end

  // level 4
  // 2 nodes
  for (genvar k = 0; k < block_size_lp/16; k++) begin : g_lvl4
    assign lvl4[k] = exp_max(lvl3[2*k], lvl3[2*k+1]);
  end

  // root of the tree
  // 31 nodes in total
  assign max_exp = exp_max(lvl4[0], lvl4[1]);

  // stage valid
  always_ff @(posedge clk) begin
    if (reset_i) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= in_valid_i;
    end
  end

  // stage payload
  always_ff @(posedge clk) begin
    max_exp_o <= max_exp;
    for (int i = 0; i < block_size_lp; i++) begin
      sign_o[i] <= block_i[i].fields.sign;
      // raw exponent kept, execute needs it for the flush
      exp_o[i]  <= lvl0[i];
      sig_o[i]  <= sig[i];
    end
  end

endmodule

`default_nettype wire

// File: hdl/bfp_align_execute.sv
`timescale 1ns/10ps
`default_nettype none

// stage 2: align each element to the shared exponent
module bfp_align_execute
  import fp32_fmt_pkg::*, bfp_code_pkg::*;
(
  input  logic                    clk,
  input  logic                    reset_i,
  input  logic                    valid_i,
  input  logic                    sign_i [block_size_lp],
  input  logic [exp_width_lp-1:0] exp_i [block_size_lp],
  input  logic [mag_width_lp-1:0] sig_i [block_size_lp],
  input  logic [exp_width_lp-1:0] max_exp_i,
  output logic                    valid_o,
  output logic                    sign_o [block_size_lp],
  output logic [mag_width_lp-1:0] mag_o [block_size_lp],
  output logic [exp_width_lp-1:0] shared_exp_o
);

  // distance from the block maximum
  // never negative, max_exp_i is the largest of exp_i
  logic [exp_width_lp-1:0]   diff [block_size_lp];

  // saturated shift amount
  logic [shift_width_lp-1:0] shamt [block_size_lp];

  // aligned magnitude, truncated
  logic [mag_width_lp-1:0]   mag [block_size_lp];

  always_comb begin
    for (int i = 0; i < block_size_lp; i++) begin
      diff[i] = max_exp_i - exp_i[i];

      // anything at or past the magnitude width shifts out fully
      if (diff[i] >= exp_width_lp'(mag_width_lp)) begin
        shamt[i] = shift_width_lp'(mag_width_lp);
      end else begin
        shamt[i] = diff[i][shift_width_lp-1:0];
      end

      // zero and subnormals flushed
      // also covers an all-zero block where diff is 0
      if (exp_i[i] == '0) begin
        mag[i] = '0;
      end else begin
        mag[i] = sig_i[i] >> shamt[i];
      end
    end
  end

  // stage valid
  always_ff @(posedge clk) begin
    if (reset_i) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= valid_i;
    end
  end

  // stage payload
  // signs and shared exponent ride along unchanged
  always_ff @(posedge clk) begin
    shared_exp_o <= max_exp_i;
    for (int i = 0; i < block_size_lp; i++) begin
      sign_o[i] <= sign_i[i];
      mag_o[i]  <= mag[i];
    end
  end

endmodule

`default_nettype wire

// File: hdl/bfp_code_result.sv
`timescale 1ns/10ps
`default_nettype none

// stage 3: code packing and output registers
module bfp_code_result
  import fp32_fmt_pkg::*, bfp_code_pkg::*;
(
  input  logic                     clk,
  input  logic                     reset_i,
  input  logic                     valid_i,
  input  logic                     sign_i [block_size_lp],
  input  logic [mag_width_lp-1:0]  mag_i [block_size_lp],
  input  logic [exp_width_lp-1:0]  shared_exp_i,
  output logic                     out_valid_o,
  output logic [exp_width_lp-1:0]  shared_exp_o,
  output logic [code_width_lp-1:0] codes_o [block_size_lp]
);

  // sign on top, magnitude below
  logic [code_width_lp-1:0] code [block_size_lp];

  always_comb begin
    for (int i = 0; i < block_size_lp; i++) begin
      code[i] = {sign_i[i], mag_i[i]};
    end
  end

  // outputs hold between blocks
  // zero after reset until the first block lands
  always_ff @(posedge clk) begin
    if (reset_i) begin
      out_valid_o  <= 1'b0;
      shared_exp_o <= '0;
      for (int i = 0; i < block_size_lp; i++) begin
        codes_o[i] <= '0;
      end
    end else begin
      out_valid_o <= valid_i;
      // load only on a live block
      if (valid_i) begin
        shared_exp_o <= shared_exp_i;
        for (int i = 0; i < block_size_lp; i++) begin
          codes_o[i] <= code[i];
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: hdl/bfp_quant_top.sv
`timescale 1ns/10ps
`default_nettype none

// block floating point quantizer, three stage pipeline
module bfp_quant_top
  import fp32_fmt_pkg::*, bfp_code_pkg::*;
(
  input  logic                     clk,
  input  logic                     reset_i,
  input  logic                     in_valid_i,
  input  logic [fp_width_lp-1:0]   block_i [block_size_lp],
  output logic                     out_valid_o,
  output logic [exp_width_lp-1:0]  shared_exp_o,
  output logic [code_width_lp-1:0] codes_o [block_size_lp]
);

  // raw words into the union
  fp32_word_u word [block_size_lp];

  // decode to execute
  logic                    dec_valid;
  logic                    dec_sign [block_size_lp];
  logic [exp_width_lp-1:0] dec_exp [block_size_lp];
  logic [mag_width_lp-1:0] dec_sig [block_size_lp];
  logic [exp_width_lp-1:0] dec_max_exp;

  // execute to result
  logic                    exe_valid;
  logic                    exe_sign [block_size_lp];
  logic [mag_width_lp-1:0] exe_mag [block_size_lp];
  logic [exp_width_lp-1:0] exe_shared_exp;

  for (genvar i = 0; i < block_size_lp; i++) begin : g_word
    assign word[i].raw = block_i[i];
  end

  bfp_exp_decode u_decode (
    .clk        (clk),
    .reset_i    (reset_i),
    .in_valid_i (in_valid_i),
    .block_i    (word),
    .valid_o    (dec_valid),
    .sign_o     (dec_sign),
    .exp_o      (dec_exp),
    .sig_o      (dec_sig),
    .max_exp_o  (dec_max_exp)
  );

  bfp_align_execute u_execute (
    .clk          (clk),
    .reset_i      (reset_i),
    .valid_i      (dec_valid),
    .sign_i       (dec_sign),
    .exp_i        (dec_exp),
    .sig_i        (dec_sig),
    .max_exp_i    (dec_max_exp),
    .valid_o      (exe_valid),
    .sign_o       (exe_sign),
    .mag_o        (exe_mag),
    .shared_exp_o (exe_shared_exp)
  );

  bfp_code_result u_result (
    .clk          (clk),
    .reset_i      (reset_i),
    .valid_i      (exe_valid),
    .sign_i       (exe_sign),
    .mag_i        (exe_mag),
    .shared_exp_i (exe_shared_exp),
    .out_valid_o  (out_valid_o),
    .shared_exp_o (shared_exp_o),
    .codes_o      (codes_o)
  );

endmodule

`default_nettype wire

// File: tb/bfp_quant_sva.sv
`timescale 1ns/10ps
`default_nettype none

// protocol checks on the top level ports
module bfp_quant_sva
  import fp32_fmt_pkg::*, bfp_code_pkg::*;
(
  input logic                    clk,
  input logic                    reset_i,
  input logic                    in_valid_i,
  input logic                    out_valid_o,
  input logic [exp_width_lp-1:0] shared_exp_o
);

  // output strobe held low through reset
  a_reset_quiet : assert property (@(posedge clk) reset_i |=> !out_valid_o)
    else $error("out_valid_o high after a reset cycle");

  // fixed pipeline depth, no stalls
  a_latency : assert property (@(posedge clk) disable iff (reset_i)
    out_valid_o == $past(in_valid_i, latency_lp))
    else $error("out_valid_o does not track in_valid_i delayed by latency_lp");

  // shared exponent only moves with a live block
  a_exp_hold : assert property (@(posedge clk) disable iff (reset_i)
    !out_valid_o |-> $stable(shared_exp_o))
    else $error("shared_exp_o changed while out_valid_o was low");

endmodule

bind bfp_quant_top bfp_quant_sva u_sva (
  .clk          (clk),
  .reset_i      (reset_i),
  .in_valid_i   (in_valid_i),
  .out_valid_o  (out_valid_o),
  .shared_exp_o (shared_exp_o)
);

`default_nettype wire

// File: tb/bfp_quant_tb.sv
`timescale 1ns/10ps
`default_nettype none

// testbench for the block floating point quantizer
module bfp_quant_tb
  import fp32_fmt_pkg::*, bfp_code_pkg::*;
;

  // golden line layout is words, then shared exponent, then codes
  localparam int num_vectors_lp    = 7;
  localparam int line_words_lp     = 2 * block_size_lp + 1;
  localparam int exp_slot_lp       = block_size_lp;
  localparam int code_base_lp      = block_size_lp + 1;
  localparam int reset_cycles_lp   = 16;
  localparam int clk_period_lp     = 4;
  localparam int watchdog_cycles_lp =
    num_vectors_lp + latency_lp + reset_cycles_lp + 20;

  logic                     clk = 1'b0;
  logic                     reset_i;
  logic                     in_valid_i;
  logic [fp_width_lp-1:0]   block_i [block_size_lp];
  logic                     out_valid_o;
  logic [exp_width_lp-1:0]  shared_exp_o;
  logic [code_width_lp-1:0] codes_o [block_size_lp];

  logic [31:0] golden_mem [num_vectors_lp * line_words_lp];

  // vector index riding alongside in_valid_i
  int in_index;
  // blocks in flight with the oldest first
  int pending_idx [$];
  int pending_cycle [$];
  int cycle_count  = 0;
  int outputs_seen = 0;
  int last_idx     = 0;
  int check_count  = 0;
  int error_count  = 0;

  bfp_quant_top dut0 (
    .clk          (clk),
    .reset_i      (reset_i),
    .in_valid_i   (in_valid_i),
    .block_i      (block_i),
    .out_valid_o  (out_valid_o),
    .shared_exp_o (shared_exp_o),
    .codes_o      (codes_o)
  );

  always #(clk_period_lp / 2) clk = ~clk;

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
  end

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("ERROR @ %0t ns: %s, got %0h, expected %0h", $time, what, actual, expected);
    end
  endtask

  // shared exponent and all codes against one golden line
  task automatic compare_block(input int idx, input string tag);
    int base;
    base = idx * line_words_lp;
    check_value(32'(shared_exp_o), golden_mem[base + exp_slot_lp],
                $sformatf("%s shared_exp_o, vector %0d", tag, idx));
    for (int i = 0; i < block_size_lp; i++) begin
      check_value(32'(codes_o[i]), golden_mem[base + code_base_lp + i],
                  $sformatf("%s codes_o[%0d], vector %0d", tag, i, idx));
    end
  endtask

  // reset value of the outputs
  task automatic check_cleared();
    check_value(32'(shared_exp_o), 32'h0, "shared_exp_o before first block");
    for (int i = 0; i < block_size_lp; i++) begin
      check_value(32'(codes_o[i]), 32'h0, $sformatf("codes_o[%0d] before first block", i));
    end
  endtask

  task automatic drive_block(input int idx);
    @(posedge clk);
    in_valid_i <= 1'b1;
    in_index   <= idx;
    for (int i = 0; i < block_size_lp; i++) begin
      block_i[i] <= golden_mem[idx * line_words_lp + i];
    end
  endtask

  task automatic drive_idle(input int cycles);
    repeat (cycles) begin
      @(posedge clk);
      in_valid_i <= 1'b0;
    end
  endtask

  // sample on the falling edge where all DUT outputs have settled
  always @(negedge clk) begin
    int idx;
    int issue_cycle;
    if (!reset_i) begin
      if (out_valid_o) begin
        if (pending_idx.size() == 0) begin
          error_count++;
          $display("out_valid_o went high at %0t ns with no block in flight", $time);
        end else begin
          idx         = pending_idx.pop_front();
          issue_cycle = pending_cycle.pop_front();
          check_value(cycle_count - issue_cycle, latency_lp,
                      $sformatf("latency in cycles, vector %0d", idx));
          compare_block(idx, "output");
          last_idx = idx;
          outputs_seen++;
        end
      end else if (outputs_seen > 0) begin
        // outputs hold the last block between strobes
        compare_block(last_idx, "hold");
      end else begin
        check_cleared();
      end
      if (in_valid_i) begin
        pending_idx.push_back(in_index);
        pending_cycle.push_back(cycle_count);
      end
    end
  end

  initial begin
    reset_i    = 1'b1;
    in_valid_i = 1'b0;
    in_index   = 0;
    for (int i = 0; i < block_size_lp; i++) begin
      block_i[i] = '0;
    end
    $readmemh("tb/bfp_golden.hex", golden_mem);
    if ($isunknown(golden_mem[num_vectors_lp * line_words_lp - 1])) begin
      error_count++;
      $display("the golden file tb/bfp_golden.hex is missing or too short");
    end

    repeat (reset_cycles_lp) @(posedge clk);
    reset_i <= 1'b0;
    // quiet cycles where outputs must still read zero
    drive_idle(2);

    // back to back blocks with three in flight at once
    for (int v = 0; v < 5; v++) begin
      drive_block(v);
    end
    drive_idle(3);
    drive_block(5);
    drive_idle(3);
    drive_block(6);
    drive_idle(1);

    while (outputs_seen < num_vectors_lp) begin
      @(posedge clk);
    end
    // a stray strobe would show up here
    drive_idle(4);

    $display("checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  // hard stop in case the pipeline never drains
  initial begin
    #(clk_period_lp * watchdog_cycles_lp);
    $display("timeout: run did not finish within %0d clock cycles", watchdog_cycles_lp);
    $display("Result: FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: bfp_quant.f
hdl/fp32_fmt_pkg.sv
hdl/bfp_code_pkg.sv
hdl/bfp_exp_decode.sv
hdl/bfp_align_execute.sv
hdl/bfp_code_result.sv
hdl/bfp_quant_top.sv
tb/bfp_quant_sva.sv
tb/bfp_quant_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the bfp_quant testbench with Verilator
# exit status is 0 only when the pass line shows up in the simulation output

cd "$(dirname "$0")" &&
verilator --binary --timing --assert \
  --top-module bfp_quant_tb \
  -f bfp_quant.f \
  -o bfp_quant_sim &&
./obj_dir/bfp_quant_sim | tee /dev/stderr | grep -qx "Result: PASSED" &&
echo "run_sim: simulation ok" && exit 0 ||
{ echo "run_sim: simulation did not pass"; exit 1; }

// File: tb/bfp_golden.hex
// one block per line: 32 input words (fp32, element 0 first), the shared exponent,
// then 32 expected codes {sign, magnitude[4:0]} in element order
41000000 C1700000 40C00000 40400000 BFC00000 3F800000 3F000000 3E800000 BE800000 00000000 80000000 00400000 41780000 40F80000 C0780000 3FF80000 41000000 C1700000 40C00000 40400000 BFC00000 3F800000 3F000000 3E800000 BE800000 00000000 80000000 00400000 41780000 40F80000 C0780000 3FF80000 82 10 3E 0C 06 23 02 01 00 20 00 20 00 1F 0F 27 03 10 3E 0C 06 23 02 01 00 20 00 20 00 1F 0F 27 03
00000000 80000000 007FFFFF 807FFFFF 00000000 80000000 007FFFFF 807FFFFF 00000000 80000000 007FFFFF 807FFFFF 00000000 80000000 007FFFFF 807FFFFF 00000000 80000000 007FFFFF 807FFFFF 00000000 80000000 007FFFFF 807FFFFF 00000000 80000000 007FFFFF 807FFFFF 00000000 80000000 007FFFFF 807FFFFF 00 00 20 00 20 00 20 00 20 00 20 00 20 00 20 00 20 00 20 00 20 00 20 00 20 00 20 00 20 00 20 00 20
47000000 BF800000 42F00000 C3700000 46FFFFFF C6800000 45800000 C5000000 47000000 BF800000 42F00000 C3700000 46FFFFFF C6800000 45800000 C5000000 47000000 BF800000 42F00000 C3700000 46FFFFFF C6800000 45800000 C5000000 47000000 BF800000 42F00000 C3700000 46FFFFFF C6800000 45800000 C5000000 8E 10 20 00 20 0F 28 02 21 10 20 00 20 0F 28 02 21 10 20 00 20 0F 28 02 21 10 20 00 20 0F 28 02 21
BF800000 3F800000 BF800000 3F800000 BF800000 3F800000 BF800000 3F800000 BF800000 3F800000 BF800000 3F800000 BF800000 3F800000 BF800000 3F800000 BF800000 3F800000 BF800000 3F800000 BF800000 3F800000 BF800000 3F800000 BF800000 3F800000 BF800000 3F800000 BF800000 3F800000 BF800000 40800000 81 24 04 24 04 24 04 24 04 24 04 24 04 24 04 24 04 24 04 24 04 24 04 24 04 24 04 24 04 24 04 24 10
7F000000 7F000000 7F000000 7F000000 7F000000 7E800000 7F000000 7F000000 7F000000 7F000000 7F000000 7F000000 7F000000 7F000000 7F000000 7F000000 7F000000 FFC00000 7F000000 7F000000 7F000000 7F000000 7F000000 7F000000 7F000000 7F000000 7F000000 7F000000 7F000000 7F000000 7F000000 7F000000 FF 08 08 08 08 08 04 08 08 08 08 08 08 08 08 08 08 08 38 08 08 08 08 08 08 08 08 08 08 08 08 08 08
3F87FFFF 3F8FFFFF 3F97FFFF 3F9FFFFF 3FA7FFFF 3FAFFFFF 3FB7FFFF 3FBFFFFF 3FC7FFFF 3FCFFFFF 3FD7FFFF 3FDFFFFF 3FE7FFFF 3FEFFFFF 3FF7FFFF 3FFFFFFF BF87FFFF BF8FFFFF BF97FFFF BF9FFFFF BFA7FFFF BFAFFFFF BFB7FFFF BFBFFFFF BFC7FFFF BFCFFFFF BFD7FFFF BFDFFFFF BFE7FFFF BFEFFFFF BFF7FFFF BFFFFFFF 7F 10 11 12 13 14 15 16 17 18 19 1A 1B 1C 1D 1E 1F 30 31 32 33 34 35 36 37 38 39 3A 3B 3C 3D 3E 3F
00800000 80FFFFFF 007FFFFF 807FFFFF 00800000 80FFFFFF 007FFFFF 807FFFFF 00800000 80FFFFFF 007FFFFF 807FFFFF 00800000 80FFFFFF 007FFFFF 807FFFFF 00800000 80FFFFFF 007FFFFF 807FFFFF 00800000 80FFFFFF 007FFFFF 807FFFFF 00800000 80FFFFFF 007FFFFF 807FFFFF 00800000 80FFFFFF 007FFFFF 807FFFFF 01 10 3F 00 20 10 3F 00 20 10 3F 00 20 10 3F 00 20 10 3F 00 20 10 3F 00 20 10 3F 00 20 10 3F 00 20
